// ==== rv_core_stim.txt ====
// Columns: instruction word, rd, wen, wdata, end kind (0 normal, 1 halt, 2 illegal).
// Section A starts at record 0, section B follows the first ebreak record.
00500093 01 1 00000005 0
ffd00113 02 1 fffffffd 0
002081b3 03 1 00000002 0
40110233 04 1 fffffff8 0
800002b7 05 1 80000000 0
00528333 06 1 00000000 0
00001397 07 1 80001018 0
00708013 00 0 0000000c 0
00100433 08 1 00000005 0
7ff20493 09 1 000007f7 0
40900533 0a 1 fffff809 0
80038593 0b 1 80000818 0
00100073 00 0 00000000 1
12300093 01 1 00000123 0
fffff117 02 1 7ffff004 0
401081b3 03 1 00000000 0
00002003 00 0 00000000 2

// ==== flist.f ====
rv_core_pkg.sv
inst_fetch.sv
inst_decode.sv
reg_file.sv
exec_unit.sv
rv_core_top.sv
rv_core_checker.sv
tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_rv_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int n_records    = 17;
    localparam int halt_timeout = 2000;
    localparam int quiet_window = 40;

    logic                  clk = 1'b0;
    logic                  rst_n = 1'b0;
    logic                  imem_req_ready = 1'b0;
    logic                  imem_rsp_valid = 1'b0;
    logic [xlen-1:0]       imem_rsp_data = '0;
    logic                  retire_ready = 1'b0;
    logic                  imem_req_valid;
    logic [xlen-1:0]       imem_req_addr;
    logic                  imem_rsp_ready;
    logic                  retire_valid;
    retire_t               retire;
    logic                  halted;
    logic [31:0]           stim [0:5*n_records-1];
    int                    sec_base = 0;
    int                    error_count;
    int                    retire_count;
    logic [31:0]           lfsr_q = 32'h40b1_d4f7;
    logic [xlen-1:0]       pend_addr;
    logic                  pend_q;
    logic [1:0]            req_wait;
    logic [1:0]            rsp_wait;
    logic [1:0]            ret_wait;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    logic                  timed_out = 1'b0;

    rv_core_top i_rv_core_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_req_ready (imem_req_ready),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_data  (imem_rsp_data),
        .retire_ready   (retire_ready),
        .imem_req_valid (imem_req_valid),
        .imem_req_addr  (imem_req_addr),
        .imem_rsp_ready (imem_rsp_ready),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .halted         (halted)
    );

    rv_core_checker #(.n_records(n_records)) rv_core_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_req_valid (imem_req_valid),
        .imem_req_ready (imem_req_ready),
        .imem_req_addr  (imem_req_addr),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_ready (imem_rsp_ready),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire         (retire),
        .halted         (halted),
        .sec_base       (sec_base),
        .stim           (stim),
        .error_count    (error_count),
        .retire_count   (retire_count)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Two LFSR steps give a stall of zero to three cycles.
    task automatic draw_delay(output logic [1:0] d);
        lfsr_q = lfsr_next(lfsr_q);
        d[1] = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        d[0] = lfsr_q[0];
    endtask

    function automatic logic [31:0] fetch_word(input logic [xlen-1:0] addr);
        int idx;
        idx = sec_base + int'((addr - reset_pc) >> 2);
        if (idx >= n_records) begin
            return 32'h0;
        end
        return stim[5*idx];
    endfunction

    // Memory and retire sinks with random stalls.
    always @(posedge clk or negedge rst_n) begin : serve_bus
        logic [1:0] d;
        if (!rst_n) begin
            imem_req_ready <= 1'b0;
            imem_rsp_valid <= 1'b0;
            retire_ready   <= 1'b0;
            pend_q         <= 1'b0;
            pend_addr      <= '0;
            req_wait       <= 2'd1;
            rsp_wait       <= 2'd0;
            ret_wait       <= 2'd2;
        end else begin
            if (imem_req_valid && imem_req_ready) begin
                imem_req_ready <= 1'b0;
                pend_q         <= 1'b1;
                pend_addr      <= imem_req_addr;
                draw_delay(d);
                rsp_wait <= d;
                draw_delay(d);
                req_wait <= d;
            end else if (imem_req_valid) begin
                if (req_wait == 2'd0) begin
                    imem_req_ready <= 1'b1;
                end else begin
                    req_wait <= req_wait - 2'd1;
                end
            end
            if (imem_rsp_valid && imem_rsp_ready) begin
                imem_rsp_valid <= 1'b0;
            end else if (pend_q && !imem_rsp_valid) begin
                if (rsp_wait == 2'd0) begin
                    imem_rsp_valid <= 1'b1;
                    imem_rsp_data  <= fetch_word(pend_addr);
                    pend_q         <= 1'b0;
                end else begin
                    rsp_wait <= rsp_wait - 2'd1;
                end
            end
            if (retire_valid && retire_ready) begin
                retire_ready <= 1'b0;
                draw_delay(d);
                ret_wait <= d;
            end else if (retire_valid) begin
                if (ret_wait == 2'd0) begin
                    retire_ready <= 1'b1;
                end else begin
                    ret_wait <= ret_wait - 2'd1;
                end
            end
        end
    end

    task automatic report(input string name, input int errs_before, input int own_errs);
        tests_run++;
        if (error_count == errs_before && own_errs == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic run_section(input string name, input int base, input int length);
        int cycles;
        int errs;
        int own;
        errs = error_count;
        own  = 0;
        sec_base = base;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (!halted && cycles < halt_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: the core did not halt in section %s", name);
            timed_out = 1'b1;
            return;
        end
        if (retire_count != length) begin
            $display("Error: section %s retired %0d instructions instead of %0d",
                     name, retire_count, length);
            own++;
        end
        report({name, "_program"}, errs, own);
        errs = error_count;
        own  = 0;
        for (int i = 0; i < quiet_window; i++) begin
            @(posedge clk);
            if (imem_req_valid || !halted) begin
                own++;
            end
        end
        if (own != 0) begin
            $display("Error: section %s fetched again or left the halted state", name);
        end
        report({name, "_stays_halted"}, errs, own);
    endtask

    initial begin
        int end_a;
        int end_b;
        $readmemh("rv_core_stim.txt", stim);
        end_a = n_records - 1;
        for (int r = n_records - 1; r >= 0; r--) begin
            if (stim[5*r+4] == 32'd1) begin
                end_a = r;
            end
        end
        end_b = n_records - 1;
        run_section("section_a", 0, end_a + 1);
        if (!timed_out) begin
            run_section("section_b", end_a + 1, end_b - end_a);
        end
        $display("tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, error_count);
        if (!timed_out && tests_failed == 0 && error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker #(
    parameter int n_records = 17
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         imem_req_valid,
    input  wire logic                         imem_req_ready,
    input  wire logic [rv_core_pkg::xlen-1:0] imem_req_addr,
    input  wire logic                         imem_rsp_valid,
    input  wire logic                         imem_rsp_ready,
    input  wire logic                         retire_valid,
    input  wire logic                         retire_ready,
    input  rv_core_pkg::retire_t              retire,
    input  wire logic                         halted,
    input  int                                sec_base,
    input  logic [31:0]                       stim [0:5*n_records-1],
    output int                                error_count,
    output int                                retire_count
);
    import rv_core_pkg::*;

    int         errors = 0;
    int         req_count;
    int         ret_count;
    logic       halt_pending;
    logic       rsp_open;
    logic [1:0] rsp_fire_d;
    logic       fetch_due;

    assign error_count  = errors;
    assign retire_count = ret_count;

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk or negedge rst_n) begin : watch
        int rec;
        if (!rst_n) begin
            req_count    <= 0;
            ret_count    <= 0;
            halt_pending <= 1'b0;
            rsp_open     <= 1'b0;
            rsp_fire_d   <= '0;
            fetch_due    <= 1'b0;
        end else begin
            // Response ready only while a request is outstanding.
            compare("response ready", 32'(imem_rsp_ready), 32'(rsp_open));
            if (imem_req_valid && imem_req_ready) begin
                compare("request address", imem_req_addr, reset_pc + 32'(4 * req_count));
                req_count <= req_count + 1;
                rsp_open  <= 1'b1;
            end
            if (imem_rsp_valid && imem_rsp_ready) begin
                rsp_open <= 1'b0;
            end
            // Retire register loads on the edge after the response.
            rsp_fire_d <= {rsp_fire_d[0], imem_rsp_valid && imem_rsp_ready};
            if (rsp_fire_d[0]) begin
                compare("retire valid before load", 32'(retire_valid), 32'h0);
            end
            if (rsp_fire_d[1]) begin
                compare("retire valid after response", 32'(retire_valid), 32'h1);
            end
            fetch_due <= 1'b0;
            if (fetch_due) begin
                compare("request valid after retire", 32'(imem_req_valid), 32'h1);
            end
            if (imem_req_valid && halted) begin
                $display("Error at %0t: a fetch request was raised after the core halted", $time);
                errors++;
            end
            // Halted must follow one cycle after a stopping retire.
            if (halt_pending) begin
                compare("halted", 32'(halted), 32'h1);
                halt_pending <= 1'b0;
            end
            if (retire_valid && retire_ready) begin
                rec = sec_base + ret_count;
                if (halted) begin
                    $display("Error at %0t: an instruction retired after the core halted", $time);
                    errors++;
                end else if (rec >= n_records) begin
                    $display("Error at %0t: more retires than the program holds", $time);
                    errors++;
                end else begin
                    compare("retire pc", retire.pc, reset_pc + 32'(4 * ret_count));
                    compare("retire rd", 32'(retire.rd), stim[5*rec+1]);
                    compare("retire wen", 32'(retire.wen), stim[5*rec+2]);
                    compare("retire wdata", retire.wdata, stim[5*rec+3]);
                    compare("retire halt", 32'(retire.halt), 32'(stim[5*rec+4] == 32'd1));
                    compare("retire illegal", 32'(retire.illegal),
                            32'(stim[5*rec+4] == 32'd2));
                end
                ret_count <= ret_count + 1;
                if (retire.halt || retire.illegal) begin
                    halt_pending <= 1'b1;
                end else begin
                    fetch_due <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         imem_req_ready,
    input  wire logic                         imem_rsp_valid,
    input  wire logic [rv_core_pkg::xlen-1:0] imem_rsp_data,
    input  wire logic                         retire_ready,
    output logic                              imem_req_valid,
    output logic [rv_core_pkg::xlen-1:0]      imem_req_addr,
    output logic                              imem_rsp_ready,
    output logic                              retire_valid,
    output rv_core_pkg::retire_t              retire,
    output logic                              halted
);
    import rv_core_pkg::*;

    inst_word_u            inst;
    logic [xlen-1:0]       inst_pc;
    logic                  inst_valid;
    logic                  retire_done;
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    dec_out_t              dec;
    logic                  rf_wen;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    inst_fetch i_inst_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_req_ready (imem_req_ready),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_data  (imem_rsp_data),
        .retire_done    (retire_done),
        .halted         (halted),
        .imem_req_valid (imem_req_valid),
        .imem_req_addr  (imem_req_addr),
        .imem_rsp_ready (imem_rsp_ready),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .inst_valid     (inst_valid)
    );

    inst_decode i_inst_decode (
        .inst    (inst),
        .inst_pc (inst_pc),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .raddr1  (raddr1),
        .raddr2  (raddr2),
        .dec     (dec)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    exec_unit i_exec_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec),
        .inst_valid   (inst_valid),
        .retire_ready (retire_ready),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_done  (retire_done),
        .rf_wen       (rf_wen),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .halted       (halted)
    );

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  rv_core_pkg::dec_out_t                  dec,
    input  wire logic                              inst_valid,
    input  wire logic                              retire_ready,
    output logic                                   retire_valid,
    output rv_core_pkg::retire_t                   retire,
    output logic                                   retire_done,
    output logic                                   rf_wen,
    output logic [rv_core_pkg::reg_addr_w-1:0]     rf_waddr,
    output logic [rv_core_pkg::xlen-1:0]           rf_wdata,
    output logic                                   halted
);
    import rv_core_pkg::*;

    logic [xlen-1:0] result;
    logic            load;

    always_comb begin
        case (dec.cmd)
            cmd_add:  result = dec.src1 + dec.src2;
            cmd_sub:  result = dec.src1 - dec.src2;
            cmd_pass: result = dec.src2;
            default:  result = '0;
        endcase
    end

    // One load per fetched word.
    assign load        = inst_valid && !retire_valid;
    assign retire_done = retire_valid && retire_ready;

    assign rf_wen   = retire_done && retire.wen;
    assign rf_waddr = retire.rd;
    assign rf_wdata = retire.wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            if (retire_done) begin
                retire_valid <= 1'b0;
            end else if (load) begin
                retire_valid <= 1'b1;
            end
            if (retire_done && (retire.halt || retire.illegal)) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            retire.pc      <= dec.pc;
            retire.rd      <= dec.rd;
            retire.wdata   <= result;
            retire.wen     <= dec.wen;
            retire.halt    <= (dec.cmd == cmd_halt);
            retire.illegal <= (dec.cmd == cmd_illegal);
        end
    end

    retire_hold: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire));

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic [rv_core_pkg::reg_addr_w-1:0] raddr1,
    input  wire logic [rv_core_pkg::reg_addr_w-1:0] raddr2,
    input  wire logic                               wen,
    input  wire logic [rv_core_pkg::reg_addr_w-1:0] waddr,
    input  wire logic [rv_core_pkg::xlen-1:0]       wdata,
    output logic [rv_core_pkg::xlen-1:0]            rdata1,
    output logic [rv_core_pkg::xlen-1:0]            rdata2
);
    import rv_core_pkg::*;

    // No storage behind x0.
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // Decode clears wen for rd of zero.
    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wen |-> waddr != '0);

endmodule

`default_nettype wire

// ==== inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  rv_core_pkg::inst_word_u             inst,
    input  wire logic [rv_core_pkg::xlen-1:0]   inst_pc,
    input  wire logic [rv_core_pkg::xlen-1:0]   rdata1,
    input  wire logic [rv_core_pkg::xlen-1:0]   rdata2,
    output logic [rv_core_pkg::reg_addr_w-1:0]  raddr1,
    output logic [rv_core_pkg::reg_addr_w-1:0]  raddr2,
    output rv_core_pkg::dec_out_t               dec
);
    import rv_core_pkg::*;

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic            is_ebreak;

    assign imm_i = {{(xlen-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
    assign imm_u = {inst.u_fmt.imm20, 12'b0};

    assign is_ebreak = (inst.i_fmt.funct3 == f3_add) &&
                       (inst.i_fmt.imm12 == imm_ebreak) &&
                       (inst.i_fmt.rs1 == '0) &&
                       (inst.i_fmt.rd == '0);

    always_comb begin
        raddr1   = '0;
        raddr2   = '0;
        dec.pc   = inst_pc;
        dec.src1 = '0;
        dec.src2 = '0;
        dec.rd   = '0;
        dec.wen  = 1'b0;
        dec.cmd  = cmd_none;
        case (inst.r_fmt.opcode)
            op_imm: begin
                if (inst.i_fmt.funct3 == f3_add) begin
                    raddr1   = inst.i_fmt.rs1;
                    dec.src1 = rdata1;
                    dec.src2 = imm_i;
                    dec.rd   = inst.i_fmt.rd;
                    dec.wen  = (inst.i_fmt.rd != '0);
                    dec.cmd  = cmd_add;
                end else begin
                    dec.cmd = cmd_illegal;
                end
            end
            op_reg: begin
                if (inst.r_fmt.funct3 == f3_add &&
                    (inst.r_fmt.funct7 == f7_add || inst.r_fmt.funct7 == f7_sub)) begin
                    raddr1   = inst.r_fmt.rs1;
                    raddr2   = inst.r_fmt.rs2;
                    dec.src1 = rdata1;
                    dec.src2 = rdata2;
                    dec.rd   = inst.r_fmt.rd;
                    dec.wen  = (inst.r_fmt.rd != '0);
                    dec.cmd  = (inst.r_fmt.funct7 == f7_sub) ? cmd_sub : cmd_add;
                end else begin
                    dec.cmd = cmd_illegal;
                end
            end
            op_lui: begin
                dec.src2 = imm_u;
                dec.rd   = inst.u_fmt.rd;
                dec.wen  = (inst.u_fmt.rd != '0);
                dec.cmd  = cmd_pass;
            end
            op_auipc: begin
                // Relative to the address this word came from.
                dec.src1 = inst_pc;
                dec.src2 = imm_u;
                dec.rd   = inst.u_fmt.rd;
                dec.wen  = (inst.u_fmt.rd != '0);
                dec.cmd  = cmd_add;
            end
            op_system: begin
                dec.cmd = is_ebreak ? cmd_halt : cmd_illegal;
            end
            default: begin
                dec.cmd = cmd_illegal;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== inst_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_fetch (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     imem_req_ready,
    input  wire logic                     imem_rsp_valid,
    input  wire logic [rv_core_pkg::xlen-1:0] imem_rsp_data,
    input  wire logic                     retire_done,
    input  wire logic                     halted,
    output logic                          imem_req_valid,
    output logic [rv_core_pkg::xlen-1:0]  imem_req_addr,
    output logic                          imem_rsp_ready,
    output rv_core_pkg::inst_word_u       inst,
    output logic [rv_core_pkg::xlen-1:0]  inst_pc,
    output logic                          inst_valid
);
    import rv_core_pkg::*;

    typedef enum logic [1:0] {st_req, st_wait, st_busy} fetch_state_e;

    fetch_state_e    state_q;
    logic [xlen-1:0] pc_q;
    logic            run_q;
    logic            req_fire;
    logic            rsp_fire;

    // First request waits one cycle after reset release.
    assign imem_req_valid = (state_q == st_req) && run_q && !halted;
    assign imem_rsp_ready = (state_q == st_wait);
    assign imem_req_addr  = pc_q;
    assign inst_pc        = pc_q;

    assign req_fire = imem_req_valid && imem_req_ready;
    assign rsp_fire = imem_rsp_valid && imem_rsp_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= st_req;
            pc_q       <= reset_pc;
            run_q      <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            case (state_q)
                st_req: begin
                    if (req_fire) begin
                        state_q <= st_wait;
                    end
                end
                st_wait: begin
                    if (rsp_fire) begin
                        state_q    <= st_busy;
                        inst_valid <= 1'b1;
                    end
                end
                st_busy: begin
                    // Next word once the current one has retired.
                    if (retire_done) begin
                        state_q    <= st_req;
                        inst_valid <= 1'b0;
                        pc_q       <= pc_q + xlen'(4);
                    end
                end
                default: state_q <= st_req;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            inst <= imem_rsp_data;
        end
    end

    req_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req_addr));

endmodule

`default_nettype wire

// ==== rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // Major opcodes of the kept instructions.
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [6:0] f7_add = 7'b0000000;
    localparam logic [6:0] f7_sub = 7'b0100000;
    localparam logic [11:0] imm_ebreak = 12'h001;

    typedef enum logic [3:0] {
        cmd_none    = 4'd0,
        cmd_add     = 4'd1,
        cmd_sub     = 4'd2,
        cmd_pass    = 4'd3,
        cmd_halt    = 4'd4,
        cmd_illegal = 4'd5
    } exu_cmd_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One fetched word, read through whichever format owns the field.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } inst_word_u;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic [reg_addr_w-1:0] rd;
        logic                  wen;
        exu_cmd_e              cmd;
    } dec_out_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       wdata;
        logic                  wen;
        logic                  halt;
        logic                  illegal;
    } retire_t;

endpackage

`default_nettype wire
